// ==== rtl/mem_cfg_pkg.sv ====
// ----------------------------------------------------------
// memory geometry package
// word, parity, address and counter widths shared by the
// parity protected memory and its controller
// ----------------------------------------------------------

package mem_cfg_pkg;

  // user data width in bits
  localparam int DWIDTH = 16;

  // number of interleaved parity groups, which must be even
  localparam int PWIDTH = 2;

  // stored word holds the parity bits on top of the data
  localparam int TWIDTH = DWIDTH + PWIDTH;

  // sixteen words need four address bits
  localparam int AWIDTH = 4;
  localparam int DEPTH = 16;

  // parity error counter width, saturates at all ones
  localparam int CWIDTH = 8;

endpackage

// ==== rtl/mem_ctrl_pkg.sv ====
// ----------------------------------------------------------
// memory controller package
// command opcodes and controller FSM state encodings
// ----------------------------------------------------------

package mem_ctrl_pkg;

  // commands carried on the request port
  typedef enum logic [1:0] {
    OP_WRITE = 2'd0,
    OP_READ  = 2'd1,
    OP_CLEAR = 2'd2
  } opcode_e;

  // one command is in flight from ST_ACCESS to ST_RESP
  typedef enum logic [2:0] {
    ST_IDLE      = 3'd0,
    ST_ACCESS    = 3'd1,
    ST_WAIT_DATA = 3'd2,
    ST_WAIT_ERR  = 3'd3,
    ST_RESP      = 3'd4
  } state_e;

endpackage

// ==== rtl/ram_port_if.sv ====
// ----------------------------------------------------------
// RAM port interface
// enables, address and parity protected data between the
// controller, the parity wrapper and the RAM array
// ----------------------------------------------------------

`timescale 1ns/1ps

interface ram_port_if;

  logic                           we;
  logic                           re;
  logic [mem_cfg_pkg::AWIDTH-1:0] addr;
  // stored words carry the parity bits in the top PWIDTH bits
  logic [mem_cfg_pkg::TWIDTH-1:0] wdata;
  logic [mem_cfg_pkg::TWIDTH-1:0] rdata;

  // controller side owns the access strobes and the address
  modport ctl (output we, re, addr);

  // parity wrapper builds the stored word and checks it on return
  modport enc (output wdata, input rdata);

  // the array consumes everything and returns the read word
  modport mem (input we, re, addr, wdata, output rdata);

endinterface

// ==== rtl/ipar_wrap.sv ====
// ----------------------------------------------------------
// interleaved parity wrapper
// adds one odd parity bit per interleaved data group on the
// write path and checks the groups on the read path, giving
// a registered error one cycle after the read data returns
// ----------------------------------------------------------

`timescale 1ns/1ps

module ipar_wrap #(
  parameter int DWIDTH = mem_cfg_pkg::DWIDTH,
  parameter int PWIDTH = mem_cfg_pkg::PWIDTH
) (
  input  logic              rclk,
  input  logic              rclk_rst_n,
  input  logic [DWIDTH-1:0] mem_wdata_in,
  input  logic              cfg_errorinj,
  input  logic              re,
  output logic [DWIDTH-1:0] mem_rdata_out,
  output logic              error,
  ram_port_if.enc           ram
);

  localparam int TWIDTH = DWIDTH + PWIDTH;
  // bits per group, rounded up so the last group is zero padded
  localparam int XWIDTH = (DWIDTH + PWIDTH - 1) / PWIDTH;

  logic                           re_q;
  logic [PWIDTH*XWIDTH-1:0]       wpad;
  logic [PWIDTH*XWIDTH-1:0]       rpad;
  logic [PWIDTH-1:0][XWIDTH-1:0]  wgrp;
  logic [PWIDTH-1:0][XWIDTH-1:0]  rgrp;
  logic [PWIDTH-1:0]              wpar;
  logic [PWIDTH-1:0]              rpar;
  logic [PWIDTH-1:0]              grp_err;

  // ----------------------------------------------------------
  // group split, parity generation and check
  // ----------------------------------------------------------
  always_comb begin
    wpad = '0;
    wpad[DWIDTH-1:0] = mem_wdata_in;
    rpad = '0;
    rpad[DWIDTH-1:0] = ram.rdata[DWIDTH-1:0];
    rpar = ram.rdata[TWIDTH-1:DWIDTH];
    // group g takes every PWIDTH-th bit starting at bit g
    for (int g = 0; g < PWIDTH; g++) begin
      for (int x = 0; x < XWIDTH; x++) begin
        wgrp[g][x] = wpad[g + x * PWIDTH];
        rgrp[g][x] = rpad[g + x * PWIDTH];
      end
    end
    // injection only corrupts the parity computation, the data stays clean
    wgrp[0][0] = wgrp[0][0] ^ cfg_errorinj;
    for (int g = 0; g < PWIDTH; g++) begin
      // odd parity so an all zero word still stores a one per group
      wpar[g] = ~^wgrp[g];
      // an even count of ones over group plus parity is an error
      grp_err[g] = ~^{rpar[g], rgrp[g]};
    end
  end

  assign ram.wdata = {wpar, mem_wdata_in};
  assign mem_rdata_out = ram.rdata[DWIDTH-1:0];

  // read data comes back one cycle after re, so the check uses re delayed
  always_ff @(posedge rclk or negedge rclk_rst_n) begin
    if (!rclk_rst_n) begin
      re_q <= 1'b0;
      error <= 1'b0;
    end else begin
      re_q <= re;
      error <= (|grp_err) & re_q;
    end
  end

  // the interleave needs an even group count to pair the data bits
  a_even_pwidth: assert property (@(posedge rclk) (PWIDTH % 2) == 0);

  // a cycle without a read can never raise the error two cycles later
  a_err_needs_re: assert property (
    @(posedge rclk) disable iff (!rclk_rst_n) !re |-> ##2 !error
  );

endmodule

// ==== rtl/par_ram.sv ====
// ----------------------------------------------------------
// parity RAM
// single port synchronous array of data plus parity words
// with a registered read one cycle after re
// ----------------------------------------------------------

`timescale 1ns/1ps

module par_ram (
  input  logic    rclk,
  ram_port_if.mem ram
);

  logic [mem_cfg_pkg::TWIDTH-1:0] mem [mem_cfg_pkg::DEPTH];

  // write on we, and register the addressed word on re
  always_ff @(posedge rclk) begin
    if (ram.we) begin
      mem[ram.addr] <= ram.wdata;
    end
    if (ram.re) begin
      ram.rdata <= mem[ram.addr];
    end
  end

  // single port, so the controller must never ask for both at once
  a_no_rw_collision: assert property (@(posedge rclk) !(ram.we && ram.re));

endmodule

// ==== rtl/mem_ctrl_fsm.sv ====
// ----------------------------------------------------------
// memory command controller
// accepts write, read and clear commands, runs the RAM
// access, collects read data and parity error, and holds the
// response until the requester takes it
// ----------------------------------------------------------

`timescale 1ns/1ps

module mem_ctrl_fsm (
  input  logic                           rclk,
  input  logic                           rclk_rst_n,
  // request port
  input  logic                           req_valid,
  output logic                           req_ready,
  input  mem_ctrl_pkg::opcode_e          req_op,
  input  logic [mem_cfg_pkg::AWIDTH-1:0] req_addr,
  input  logic [mem_cfg_pkg::DWIDTH-1:0] req_wdata,
  // response port
  output logic                           rsp_valid,
  input  logic                           rsp_ready,
  output logic [mem_cfg_pkg::DWIDTH-1:0] rsp_rdata,
  output logic                           rsp_err,
  // RAM strobes and parity wrapper data
  ram_port_if.ctl                        ram,
  output logic [mem_cfg_pkg::DWIDTH-1:0] wr_data,
  output logic                           rd_en,
  input  logic [mem_cfg_pkg::DWIDTH-1:0] rd_data,
  input  logic                           par_err,
  // error counter clear
  output logic                           clr
);

  mem_ctrl_pkg::state_e           state;
  mem_ctrl_pkg::state_e           state_nxt;
  mem_ctrl_pkg::opcode_e          op_q;
  logic [mem_cfg_pkg::AWIDTH-1:0] addr_q;
  logic [mem_cfg_pkg::DWIDTH-1:0] wdata_q;
  logic                           accept;
  logic                           in_access;

  assign req_ready = (state == mem_ctrl_pkg::ST_IDLE);
  assign accept = req_valid && req_ready;
  assign rsp_valid = (state == mem_ctrl_pkg::ST_RESP);
  assign in_access = (state == mem_ctrl_pkg::ST_ACCESS);

  // ----------------------------------------------------------
  // state register and next state
  // ----------------------------------------------------------
  always_ff @(posedge rclk or negedge rclk_rst_n) begin
    if (!rclk_rst_n) begin
      state <= mem_ctrl_pkg::ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      mem_ctrl_pkg::ST_IDLE: begin
        if (req_valid) begin
          state_nxt = mem_ctrl_pkg::ST_ACCESS;
        end
      end
      // only reads wait for the RAM and then for the registered check
      mem_ctrl_pkg::ST_ACCESS: begin
        if (op_q == mem_ctrl_pkg::OP_READ) begin
          state_nxt = mem_ctrl_pkg::ST_WAIT_DATA;
        end else begin
          state_nxt = mem_ctrl_pkg::ST_RESP;
        end
      end
      mem_ctrl_pkg::ST_WAIT_DATA: state_nxt = mem_ctrl_pkg::ST_WAIT_ERR;
      mem_ctrl_pkg::ST_WAIT_ERR:  state_nxt = mem_ctrl_pkg::ST_RESP;
      mem_ctrl_pkg::ST_RESP: begin
        if (rsp_ready) begin
          state_nxt = mem_ctrl_pkg::ST_IDLE;
        end
      end
      default: state_nxt = mem_ctrl_pkg::ST_IDLE;
    endcase
  end

  // ----------------------------------------------------------
  // command and response payload
  // ----------------------------------------------------------
  always_ff @(posedge rclk) begin
    if (accept) begin
      op_q <= req_op;
      addr_q <= req_addr;
      wdata_q <= req_wdata;
      // writes and clears answer with zero data and no error
      rsp_rdata <= '0;
      rsp_err <= 1'b0;
    end
    // RAM word is on rd_data one cycle after re
    if (state == mem_ctrl_pkg::ST_WAIT_DATA) begin
      rsp_rdata <= rd_data;
    end
    // the wrapper's registered error lags the data by one more cycle
    if (state == mem_ctrl_pkg::ST_WAIT_ERR) begin
      rsp_err <= par_err;
    end
  end

  // strobes last exactly the one ST_ACCESS cycle
  assign ram.we = in_access && (op_q == mem_ctrl_pkg::OP_WRITE);
  assign ram.re = in_access && (op_q == mem_ctrl_pkg::OP_READ);
  assign ram.addr = addr_q;
  assign rd_en = ram.re;
  assign clr = in_access && (op_q == mem_ctrl_pkg::OP_CLEAR);
  assign wr_data = wdata_q;

  // a stalled response keeps its valid and its payload
  a_rsp_hold: assert property (
    @(posedge rclk) disable iff (!rclk_rst_n)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata) && $stable(rsp_err)
  );

  // ready only comes back once the pending response has been taken
  a_one_in_flight: assert property (
    @(posedge rclk) disable iff (!rclk_rst_n)
    !req_ready && !(rsp_valid && rsp_ready) |=> !req_ready
  );

endmodule

// ==== rtl/err_counter.sv ====
// ----------------------------------------------------------
// parity error counter
// saturating event counter, a clear wins over an increment
// ----------------------------------------------------------

`timescale 1ns/1ps

module err_counter (
  input  logic                           rclk,
  input  logic                           rclk_rst_n,
  input  logic                           inc,
  input  logic                           clr,
  output logic [mem_cfg_pkg::CWIDTH-1:0] count
);

  always_ff @(posedge rclk or negedge rclk_rst_n) begin
    if (!rclk_rst_n) begin
      count <= '0;
    end else if (clr) begin
      count <= '0;
    end else if (inc && (count != '1)) begin
      // stick at all ones once the counter is full
      count <= count + 1'b1;
    end
  end

  // without a clear the count can only hold or grow
  a_monotonic: assert property (
    @(posedge rclk) disable iff (!rclk_rst_n) !clr |=> count >= $past(count)
  );

endmodule

// ==== rtl/par_mem_top.sv ====
// ----------------------------------------------------------
// parity protected memory top level
// controller, interleaved parity wrapper, RAM array and
// error counter behind plain request and response ports
// ----------------------------------------------------------

`timescale 1ns/1ps

module par_mem_top (
  input  logic                           rclk,
  input  logic                           rclk_rst_n,
  input  logic                           req_valid,
  output logic                           req_ready,
  input  logic [1:0]                     req_op,
  input  logic [mem_cfg_pkg::AWIDTH-1:0] req_addr,
  input  logic [mem_cfg_pkg::DWIDTH-1:0] req_wdata,
  output logic                           rsp_valid,
  input  logic                           rsp_ready,
  output logic [mem_cfg_pkg::DWIDTH-1:0] rsp_rdata,
  output logic                           rsp_err,
  input  logic                           cfg_errorinj,
  output logic [mem_cfg_pkg::CWIDTH-1:0] err_count
);

  logic [mem_cfg_pkg::DWIDTH-1:0] wr_data;
  logic [mem_cfg_pkg::DWIDTH-1:0] rd_data;
  logic                           rd_en;
  logic                           par_err;
  logic                           clr;

  ram_port_if ram_if ();

  mem_ctrl_fsm u_ctrl (
    .rclk       (rclk),
    .rclk_rst_n (rclk_rst_n),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req_op     (mem_ctrl_pkg::opcode_e'(req_op)),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .rsp_valid  (rsp_valid),
    .rsp_ready  (rsp_ready),
    .rsp_rdata  (rsp_rdata),
    .rsp_err    (rsp_err),
    .ram        (ram_if.ctl),
    .wr_data    (wr_data),
    .rd_en      (rd_en),
    .rd_data    (rd_data),
    .par_err    (par_err),
    .clr        (clr)
  );

  ipar_wrap #(
    .DWIDTH (mem_cfg_pkg::DWIDTH),
    .PWIDTH (mem_cfg_pkg::PWIDTH)
  ) u_par (
    .rclk          (rclk),
    .rclk_rst_n    (rclk_rst_n),
    .mem_wdata_in  (wr_data),
    .cfg_errorinj  (cfg_errorinj),
    .re            (rd_en),
    .mem_rdata_out (rd_data),
    .error         (par_err),
    .ram           (ram_if.enc)
  );

  par_ram u_ram (
    .rclk (rclk),
    .ram  (ram_if.mem)
  );

  // the same error pulse feeds the response and the counter
  err_counter u_cnt (
    .rclk       (rclk),
    .rclk_rst_n (rclk_rst_n),
    .inc        (par_err),
    .clr        (clr),
    .count      (err_count)
  );

endmodule

// ==== tests/tb_par_mem.sv ====
// ----------------------------------------------------------
// parity protected memory testbench
// directed tests for writes, reads, parity error injection,
// response back-pressure and the saturating error counter
// ----------------------------------------------------------

`timescale 1ns/1ps

module tb_par_mem;

  localparam int CLK_PERIOD = 10;
  localparam int RST_CYCLES = 8;
  localparam int AWIDTH = mem_cfg_pkg::AWIDTH;
  localparam int DWIDTH = mem_cfg_pkg::DWIDTH;
  localparam int CWIDTH = mem_cfg_pkg::CWIDTH;
  localparam int N_TESTS = 5;
  // the saturation sweep is the longest test at about 1600 cycles
  localparam int TEST_CYCLES = 2500;

  logic              rclk;
  logic              rclk_rst_n;
  logic              req_valid;
  logic              req_ready;
  logic [1:0]        req_op;
  logic [AWIDTH-1:0] req_addr;
  logic [DWIDTH-1:0] req_wdata;
  logic              rsp_valid;
  logic              rsp_ready;
  logic [DWIDTH-1:0] rsp_rdata;
  logic              rsp_err;
  logic              cfg_errorinj;
  logic [CWIDTH-1:0] err_count;

  // reference contents and whether the word was stored with a bad parity
  logic [DWIDTH-1:0] model [mem_cfg_pkg::DEPTH];
  logic              model_err [mem_cfg_pkg::DEPTH];
  logic [31:0]       lfsr;
  logic              stall_en;
  int                errors;
  int                checks;

  par_mem_top u_dut (
    .rclk         (rclk),
    .rclk_rst_n   (rclk_rst_n),
    .req_valid    (req_valid),
    .req_ready    (req_ready),
    .req_op       (req_op),
    .req_addr     (req_addr),
    .req_wdata    (req_wdata),
    .rsp_valid    (rsp_valid),
    .rsp_ready    (rsp_ready),
    .rsp_rdata    (rsp_rdata),
    .rsp_err      (rsp_err),
    .cfg_errorinj (cfg_errorinj),
    .err_count    (err_count)
  );

  always #(CLK_PERIOD / 2) rclk = ~rclk;

  // galois LFSR on x^32 + x^22 + x^2 + x + 1, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("mismatch at %0t ns: %s expected %0h got %0h", $time, what, exp, act);
    end
  endtask

  // ----------------------------------------------------------
  // one command through both handshakes
  // ----------------------------------------------------------
  task automatic issue_cmd(
    input  logic [1:0]        op,
    input  logic [AWIDTH-1:0] addr,
    input  logic [DWIDTH-1:0] wdata,
    output logic [DWIDTH-1:0] rdata,
    output logic              err,
    output int                lat
  );
    logic [DWIDTH-1:0] held_data;
    logic              held_err;
    @(negedge rclk);
    req_valid = 1'b1;
    req_op = op;
    req_addr = addr;
    req_wdata = wdata;
    // a ready seen at the falling edge means the transfer is on the next rising edge
    while (!req_ready) begin
      @(negedge rclk);
    end
    @(negedge rclk);
    req_valid = 1'b0;
    // lat counts rising edges from the transfer until rsp_valid is sampled high
    lat = 1;
    while (!rsp_valid) begin
      @(negedge rclk);
      lat++;
    end
    held_data = rsp_rdata;
    held_err = rsp_err;
    rsp_ready = stall_en ? (rand_bits(1) != 0) : 1'b1;
    while (!rsp_ready) begin
      @(negedge rclk);
      // a stalled response must keep valid and payload
      check_val("rsp_valid under stall", 1, rsp_valid);
      check_val("rsp_rdata under stall", held_data, rsp_rdata);
      check_val("rsp_err under stall", held_err, rsp_err);
      rsp_ready = (rand_bits(1) != 0);
    end
    @(negedge rclk);
    // exactly one response per command, so valid drops after the transfer
    check_val("rsp_valid after transfer", 0, rsp_valid);
    rdata = held_data;
    err = held_err;
  endtask

  task automatic do_write(input logic [AWIDTH-1:0] addr, input logic [DWIDTH-1:0] data);
    logic [DWIDTH-1:0] rd;
    logic              err;
    int                lat;
    issue_cmd(mem_ctrl_pkg::OP_WRITE, addr, data, rd, err, lat);
    model[addr] = data;
    // an injected write stores a word whose group 0 parity is wrong
    model_err[addr] = cfg_errorinj;
    check_val("write latency", 2, lat);
    check_val("write rsp_rdata", 0, rd);
    check_val("write rsp_err", 0, err);
  endtask

  task automatic do_read(input logic [AWIDTH-1:0] addr);
    logic [DWIDTH-1:0] rd;
    logic              err;
    int                lat;
    issue_cmd(mem_ctrl_pkg::OP_READ, addr, '0, rd, err, lat);
    check_val("read latency", 4, lat);
    check_val("read rsp_rdata", model[addr], rd);
    check_val("read rsp_err", model_err[addr], err);
  endtask

  task automatic do_clear();
    logic [DWIDTH-1:0] rd;
    logic              err;
    int                lat;
    issue_cmd(mem_ctrl_pkg::OP_CLEAR, '0, '0, rd, err, lat);
    check_val("clear latency", 2, lat);
    check_val("clear rsp_rdata", 0, rd);
    check_val("clear rsp_err", 0, err);
  endtask

  // ----------------------------------------------------------
  // directed tests
  // ----------------------------------------------------------
  task automatic check_reset_state();
    check_val("req_ready after reset", 1, req_ready);
    check_val("rsp_valid after reset", 0, rsp_valid);
    check_val("err_count after reset", 0, err_count);
  endtask

  task automatic sweep_all_words();
    for (int a = 0; a < mem_cfg_pkg::DEPTH; a++) begin
      do_write(AWIDTH'(a), DWIDTH'(rand_bits(DWIDTH)));
    end
    for (int a = 0; a < mem_cfg_pkg::DEPTH; a++) begin
      do_read(AWIDTH'(a));
    end
  endtask

  task automatic inject_parity_error();
    logic [AWIDTH-1:0] bad;
    bad = AWIDTH'(rand_bits(AWIDTH));
    // the sweep read only clean words, so nothing has been counted yet
    check_val("err_count before injection", 0, err_count);
    cfg_errorinj = 1'b1;
    do_write(bad, DWIDTH'(rand_bits(DWIDTH)));
    cfg_errorinj = 1'b0;
    // the data comes back intact but flagged
    do_read(bad);
    check_val("err_count after injected read", 1, err_count);
    do_read(bad + 4'd1);
    do_read(bad ^ 4'd8);
    check_val("err_count after clean reads", 1, err_count);
  endtask

  task automatic stall_responses();
    logic [AWIDTH-1:0] a;
    stall_en = 1'b1;
    for (int i = 0; i < 40; i++) begin
      a = AWIDTH'(rand_bits(AWIDTH));
      if (rand_bits(1) != 0) begin
        do_write(a, DWIDTH'(rand_bits(DWIDTH)));
      end else begin
        do_read(a);
      end
    end
    stall_en = 1'b0;
    rsp_ready = 1'b1;
  endtask

  task automatic count_and_saturate();
    int exp_cnt;
    do_clear();
    check_val("err_count after clear", 0, err_count);
    cfg_errorinj = 1'b1;
    do_write(4'd5, DWIDTH'(rand_bits(DWIDTH)));
    cfg_errorinj = 1'b0;
    // every bad read adds one until the counter sticks at all ones
    for (int i = 0; i < 260; i++) begin
      do_read(4'd5);
      exp_cnt = (i + 1 > 255) ? 255 : i + 1;
      check_val("err_count while counting", exp_cnt, err_count);
    end
    do_clear();
    check_val("err_count after second clear", 0, err_count);
  endtask

  initial begin
    rclk = 1'b0;
    rclk_rst_n = 1'b0;
    req_valid = 1'b0;
    req_op = '0;
    req_addr = '0;
    req_wdata = '0;
    rsp_ready = 1'b1;
    cfg_errorinj = 1'b0;
    stall_en = 1'b0;
    errors = 0;
    checks = 0;
    lfsr = 32'h9e78_6092;
    for (int a = 0; a < mem_cfg_pkg::DEPTH; a++) begin
      model[a] = '0;
      model_err[a] = 1'b0;
    end
    repeat (RST_CYCLES) @(negedge rclk);
    rclk_rst_n = 1'b1;
    @(negedge rclk);
    check_reset_state();
    sweep_all_words();
    inject_parity_error();
    stall_responses();
    count_and_saturate();
    $display("checks: %0d errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // watchdog sized from the number of tests and the bound per test
  initial begin
    #((N_TESTS * TEST_CYCLES + RST_CYCLES) * CLK_PERIOD);
    errors++;
    $display("timeout: the tests did not finish within %0d cycles", N_TESTS * TEST_CYCLES);
    $display("checks: %0d errors: %0d", checks, errors);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// ==== all.f ====
rtl/mem_cfg_pkg.sv
rtl/mem_ctrl_pkg.sv
rtl/ram_port_if.sv
rtl/ipar_wrap.sv
rtl/par_ram.sv
rtl/mem_ctrl_fsm.sv
rtl/err_counter.sv
rtl/par_mem_top.sv
tests/tb_par_mem.sv

// ==== Makefile ====
# Verilator build and run for the parity protected memory testbench

VERILATOR ?= verilator
TOP       ?= tb_par_mem
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= *** TEST PASSED ***

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(shell cat $(FILELIST)) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run fails unless the pass message shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
